// ==== design/rf_pg_defines.svh ====
//--------------------------------------------------
// Register-file bank size and power-switch chain
// parameters shared by the packages and RTL
//--------------------------------------------------

`ifndef RF_PG_DEFINES_SVH
`define RF_PG_DEFINES_SVH

// Number of words held by the bank
`define RF_DEPTH 32

// Bits per word
`define RF_WIDTH 8

// Address bits, log2 of the depth
`define RF_AWIDTH 5

// Number of power-switch stages between the enable and its acknowledge.
// This also sets the power-up and power-down latency in rclk cycles
`define RF_PG_STAGES 4

`endif

// ==== design/rf_mem_pkg.sv ====
//--------------------------------------------------
// Memory access types for the register-file bank
//--------------------------------------------------

`default_nettype none

`include "rf_pg_defines.svh"

package rf_mem_pkg;

    // Word address and word data as they appear on both ports
    typedef logic [`RF_AWIDTH-1:0] rf_addr_t;
    typedef logic [`RF_WIDTH-1:0]  rf_data_t;

    // Write port request, sampled on wclk.
    // we is a plain strobe, one word per cycle
    typedef struct packed {
        logic     we;
        rf_addr_t waddr;
        rf_data_t wdata;
    } rf_wr_req_t;

    // Read port request, sampled on rclk.
    // Data comes back one cycle after re
    typedef struct packed {
        logic     re;
        rf_addr_t raddr;
    } rf_rd_req_t;

endpackage

`default_nettype wire

// ==== design/rf_pwr_pkg.sv ====
//--------------------------------------------------
// Power management types for the bank sequencer
//--------------------------------------------------

`default_nettype none

package rf_pwr_pkg;

    // Sequencer states.
    // ON       array powered, outputs live
    // ISOLATE  outputs clamped, power still on
    // OFF      power enable removed from the switch chain
    // WAKE     power enable applied, waiting for the chain to settle
    typedef enum logic [1:0] {
        PWR_ON      = 2'b00,
        PWR_ISOLATE = 2'b01,
        PWR_OFF     = 2'b10,
        PWR_WAKE    = 2'b11
    } pwr_state_t;

    // Status word seen from outside the top level.
    // pwr_on is high only in PWR_ON, so it marks the end of the wake latency
    typedef struct packed {
        pwr_state_t state;
        logic       pwr_on;
        logic       isolated;
    } pwr_status_t;

endpackage

`default_nettype wire

// ==== design/rf_reset_sync.sv ====
//--------------------------------------------------
// Reset synchronizer on rclk with scan bypass
//--------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module rf_reset_sync (
     input  wire logic rclk
    ,input  wire logic arst_n
    ,input  wire logic fscan_rstbypen
    ,input  wire logic fscan_byprst_b
    ,output logic      rst_n_sync
);

    // Two-stage shift, assertion is asynchronous and release is clocked
    logic [1:0] sync_q;

    always_ff @(posedge rclk or negedge arst_n) begin
        if (!arst_n) begin
            sync_q <= 2'b00;
        end else begin
            // Shift a one in from the bottom, release after two edges
            sync_q <= {sync_q[0], 1'b1};
        end
    end

    // Scan mode hands reset control straight to the tester
    always_comb begin
        if (fscan_rstbypen) begin
            rst_n_sync = fscan_byprst_b;
        end else begin
            rst_n_sync = sync_q[1];
        end
    end

endmodule

`default_nettype wire

// ==== design/rf_pwr_switch_chain.sv ====
//--------------------------------------------------
// Modelled chain of power-switch stages that turns
// the array on or off one stage per rclk cycle
//--------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "rf_pg_defines.svh"

module rf_pwr_switch_chain (
     input  wire logic rclk
    ,input  wire logic rst_n
    ,input  wire logic pwr_enable_b_in
    ,output logic      pwr_enable_b_out
);

    // Each bit is one switch stage, low means the stage conducts
    logic [`RF_PG_STAGES-1:0] stage_q;

    // The enable ripples through the stages so that the inrush
    // current is spread out. Reset leaves every stage conducting,
    // which matches the sequencer coming out of reset in PWR_ON
    always_ff @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            stage_q <= '0;
        end else begin
            stage_q <= {stage_q[`RF_PG_STAGES-2:0], pwr_enable_b_in};
        end
    end

    // The far end of the chain is the acknowledge.
    // It settles RF_PG_STAGES cycles after the enable changes, in either direction
    assign pwr_enable_b_out = stage_q[`RF_PG_STAGES-1];

endmodule

`default_nettype wire

// ==== design/rf_array.sv ====
//--------------------------------------------------
// Behavioral two-port storage array with registered
// read port, power gating and output isolation
//--------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "rf_pg_defines.svh"

module rf_array
    import rf_mem_pkg::*;
(
     input  wire logic                 wclk
    ,input  wire logic                 rclk
    ,input  wire logic                 rst_n
    ,input  wire rf_wr_req_t           wr
    ,input  wire rf_rd_req_t           rd
    ,input  wire logic                 isol_en
    ,input  wire logic                 pwr_enable_b
    ,output logic [`RF_WIDTH-1:0]      rdata
);

    // Storage, one entry per address
    rf_data_t mem [`RF_DEPTH];

    // Read data register, feeds the isolation clamp
    rf_data_t rdata_q;

    // The acknowledge from the end of the switch chain is active low
    logic powered;

    assign powered = !pwr_enable_b;

    //--------------------------------------------------
    // Write port
    //--------------------------------------------------

    // A write only lands while the whole chain reports power.
    // Anything issued during power-down is simply dropped
    always_ff @(posedge wclk) begin
        if (wr.we && powered) begin
            mem[wr.waddr] <= wr.wdata;
        end
    end

    //--------------------------------------------------
    // Read port
    //--------------------------------------------------

    // Data shows up one rclk after re and holds while re is low
    always_ff @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_q <= '0;
        end else if (rd.re && powered) begin
            rdata_q <= mem[rd.raddr];
        end
    end

    // Clamp to zero so that a collapsing array never drives
    // garbage into the powered logic around it
    always_comb begin
        if (isol_en) begin
            rdata = '0;
        end else begin
            rdata = rdata_q;
        end
    end

endmodule

`default_nettype wire

// ==== design/rf_pg_bank.sv ====
//--------------------------------------------------
// Power-gated 32x8 register-file bank wrapper with
// reset sync, switch chain and storage array
//--------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "rf_pg_defines.svh"

module rf_pg_bank
    import rf_mem_pkg::*;
(
     input  wire logic                 wclk
    ,input  wire logic                 rclk
    ,input  wire logic                 arst_n

    // Memory ports
    ,input  wire rf_wr_req_t           wr
    ,input  wire rf_rd_req_t           rd
    ,output logic [`RF_WIDTH-1:0]      rdata

    // Power interface
    ,input  wire logic                 isol_en
    ,input  wire logic                 pwr_enable_b
    ,output logic                      pwr_enable_b_out

    // Scan reset bypass
    ,input  wire logic                 fscan_rstbypen
    ,input  wire logic                 fscan_byprst_b
);

    // Bank reset after synchronization to rclk
    logic rst_n_sync;

    // Acknowledge from the far end of the switch chain
    logic chain_enable_b;

    //--------------------------------------------------
    // Reset synchronizer
    //--------------------------------------------------

    rf_reset_sync rf_reset_sync_i (
         .rclk              (rclk)
        ,.arst_n            (arst_n)
        ,.fscan_rstbypen    (fscan_rstbypen)
        ,.fscan_byprst_b    (fscan_byprst_b)
        ,.rst_n_sync        (rst_n_sync)
    );

    //--------------------------------------------------
    // Power switch chain
    //--------------------------------------------------

    rf_pwr_switch_chain rf_pwr_switch_chain_i (
         .rclk              (rclk)
        ,.rst_n             (rst_n_sync)
        ,.pwr_enable_b_in   (pwr_enable_b)
        ,.pwr_enable_b_out  (chain_enable_b)
    );

    // The array runs off the settled chain output, not the raw enable.
    // The same signal goes back to the sequencer as its acknowledge
    assign pwr_enable_b_out = chain_enable_b;

    //--------------------------------------------------
    // Storage
    //--------------------------------------------------

    rf_array rf_array_i (
         .wclk              (wclk)
        ,.rclk              (rclk)
        ,.rst_n             (rst_n_sync)
        ,.wr                (wr)
        ,.rd                (rd)
        ,.isol_en           (isol_en)
        ,.pwr_enable_b      (chain_enable_b)
        ,.rdata             (rdata)
    );

endmodule

`default_nettype wire

// ==== design/rf_pwr_ctrl.sv ====
//--------------------------------------------------
// Power sequencer FSM, orders isolation against the
// power enable and tracks the chain acknowledge
//--------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module rf_pwr_ctrl
    import rf_pwr_pkg::*;
(
     input  wire logic     rclk
    ,input  wire logic     arst_n
    ,input  wire logic     sleep_req
    ,input  wire logic     pwr_enable_b_out
    ,output logic          isol_en
    ,output logic          pwr_enable_b
    ,output pwr_status_t   status
);

    pwr_state_t state_q;
    pwr_state_t state_nxt;

    // Outputs come straight from flops so they never glitch
    logic isol_q;
    logic pwr_enable_b_q;

    //--------------------------------------------------
    // Next state
    //--------------------------------------------------

    always_comb begin
        state_nxt = state_q;
        case (state_q)
            PWR_ON: begin
                if (sleep_req) begin
                    state_nxt = PWR_ISOLATE;
                end
            end
            PWR_ISOLATE: begin
                // Isolation has been up for one cycle, power can go
                state_nxt = PWR_OFF;
            end
            PWR_OFF: begin
                // Wait for the chain to report fully off before waking.
                // Waking on a stale low acknowledge would reopen the
                // outputs while switch stages are still turning off
                if (!sleep_req && pwr_enable_b_out) begin
                    state_nxt = PWR_WAKE;
                end
            end
            PWR_WAKE: begin
                // Length of this state depends on the chain latency
                if (!pwr_enable_b_out) begin
                    state_nxt = PWR_ON;
                end
            end
            default: begin
                state_nxt = PWR_ON;
            end
        endcase
    end

    //--------------------------------------------------
    // State and output flops
    //--------------------------------------------------

    // Isolation is on in every state but PWR_ON, and the enable is
    // removed only in PWR_OFF. Both are decoded from the next state
    // so they change on the same edge as the state itself
    always_ff @(posedge rclk or negedge arst_n) begin
        if (!arst_n) begin
            state_q        <= PWR_ON;
            isol_q         <= 1'b0;
            pwr_enable_b_q <= 1'b0;
        end else begin
            state_q        <= state_nxt;
            isol_q         <= (state_nxt != PWR_ON);
            pwr_enable_b_q <= (state_nxt == PWR_OFF);
        end
    end

    assign isol_en      = isol_q;
    assign pwr_enable_b = pwr_enable_b_q;

    // Status for the outside world
    always_comb begin
        status.state    = state_q;
        status.pwr_on   = (state_q == PWR_ON);
        status.isolated = isol_q;
    end

endmodule

`default_nettype wire

// ==== design/rf_pg_top.sv ====
//--------------------------------------------------
// Top level, power sequencer driving the bank
//--------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "rf_pg_defines.svh"

module rf_pg_top
    import rf_mem_pkg::*;
    import rf_pwr_pkg::*;
(
     input  wire logic                 wclk
    ,input  wire logic                 rclk
    ,input  wire logic                 arst_n
    ,input  wire logic                 sleep_req
    ,input  wire rf_wr_req_t           wr
    ,input  wire rf_rd_req_t           rd
    ,input  wire logic                 fscan_rstbypen
    ,input  wire logic                 fscan_byprst_b
    ,output logic [`RF_WIDTH-1:0]      rdata
    ,output pwr_status_t               status
);

    // Power handshake between the sequencer and the bank
    logic isol_en;
    logic pwr_enable_b;
    logic pwr_enable_b_out;

    rf_pwr_ctrl rf_pwr_ctrl_i (
         .rclk              (rclk)
        ,.arst_n            (arst_n)
        ,.sleep_req         (sleep_req)
        ,.pwr_enable_b_out  (pwr_enable_b_out)
        ,.isol_en           (isol_en)
        ,.pwr_enable_b      (pwr_enable_b)
        ,.status            (status)
    );

    rf_pg_bank rf_pg_bank_i (
         .wclk              (wclk)
        ,.rclk              (rclk)
        ,.arst_n            (arst_n)
        ,.wr                (wr)
        ,.rd                (rd)
        ,.rdata             (rdata)
        ,.isol_en           (isol_en)
        ,.pwr_enable_b      (pwr_enable_b)
        ,.pwr_enable_b_out  (pwr_enable_b_out)
        ,.fscan_rstbypen    (fscan_rstbypen)
        ,.fscan_byprst_b    (fscan_byprst_b)
    );

endmodule

`default_nettype wire

// ==== tests/rf_pg_tb.sv ====
//--------------------------------------------------
// Testbench for the power-gated register-file bank
//--------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "rf_pg_defines.svh"

module rf_pg_tb
    import rf_mem_pkg::*;
    import rf_pwr_pkg::*;
();

    logic                   wclk;
    logic                   rclk;
    logic                   arst_n;
    logic                   sleep_req;
    rf_wr_req_t             wr;
    rf_rd_req_t             rd;
    logic                   fscan_rstbypen;
    logic                   fscan_byprst_b;
    logic [`RF_WIDTH-1:0]   rdata;
    pwr_status_t            status;

    // Random stimulus state and the expected array contents
    integer   seed;
    rf_data_t sb [`RF_DEPTH];

    int err_cnt;
    int check_cnt;
    int test_cnt;
    int err_base;
    int check_base;

    rf_pg_top rf_pg_top_i (
         .wclk              (wclk)
        ,.rclk              (rclk)
        ,.arst_n            (arst_n)
        ,.sleep_req         (sleep_req)
        ,.wr                (wr)
        ,.rd                (rd)
        ,.fscan_rstbypen    (fscan_rstbypen)
        ,.fscan_byprst_b    (fscan_byprst_b)
        ,.rdata             (rdata)
        ,.status            (status)
    );

    // Both clocks come from one source, so they stay in phase
    always begin
        #50;
        wclk = ~wclk;
        rclk = ~rclk;
    end

    //--------------------------------------------------
    // Checking and bookkeeping
    //--------------------------------------------------

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_cnt++;
        assert (got === exp) else begin
            $display("ERROR: %s got 0x%0h, expected 0x%0h at %0t ns", name, got, exp, $time);
            err_cnt++;
        end
    endtask

    // Outputs are sampled on the falling edge, half a cycle after they move
    task automatic check_status(input pwr_state_t st, input logic on, input logic iso);
        check_value("status.state", status.state, st);
        check_value("status.pwr_on", status.pwr_on, on);
        check_value("status.isolated", status.isolated, iso);
    endtask

    task automatic start_test();
        err_base   = err_cnt;
        check_base = check_cnt;
        test_cnt++;
    endtask

    task automatic end_test(input string name);
        $display("Test %0d %s: %0d checks, %0d errors", test_cnt, name,
                 check_cnt - check_base, err_cnt - err_base);
    endtask

    //--------------------------------------------------
    // Bus tasks that change inputs on the falling edge
    //--------------------------------------------------

    task automatic write_word(input rf_addr_t a, input rf_data_t d);
        @(negedge wclk);
        wr.we    = 1'b1;
        wr.waddr = a;
        wr.wdata = d;
        @(negedge wclk);
        wr.we    = 1'b0;
    endtask

    // Data is due one edge after the strobe and must hold with re low
    task automatic read_check(input rf_addr_t a, input rf_data_t exp);
        @(negedge rclk);
        rd.re    = 1'b1;
        rd.raddr = a;
        @(negedge rclk);
        check_value("rdata", rdata, exp);
        rd.re    = 1'b0;
        rd.raddr = $random(seed);
        @(negedge rclk);
        check_value("rdata (hold)", rdata, exp);
    endtask

    // Wake latency depends on the switch chain, so poll with a limit.
    // Until pwr_on returns the outputs must stay isolated and clamped
    task automatic wait_pwr_on(input int max_cycles);
        int n;
        n = 0;
        while (!status.pwr_on && n < max_cycles) begin
            check_value("status.isolated", status.isolated, 1'b1);
            check_value("rdata", rdata, 8'h00);
            @(negedge rclk);
            n++;
        end
        if (!status.pwr_on) begin
            $display("Timeout: pwr_on did not return within %0d cycles after wake", max_cycles);
            err_cnt++;
        end
    endtask

    //--------------------------------------------------
    // Test sequence
    //--------------------------------------------------

    initial begin
        rf_addr_t a;
        rf_data_t d;

        seed           = 32'h7aef7323;
        err_cnt        = 0;
        check_cnt      = 0;
        test_cnt       = 0;
        wclk           = 1'b0;
        rclk           = 1'b0;
        arst_n         = 1'b0;
        sleep_req      = 1'b0;
        wr             = '0;
        rd             = '0;
        fscan_rstbypen = 1'b0;
        fscan_byprst_b = 1'b1;

        repeat (16) @(negedge rclk);
        arst_n = 1'b1;
        // Bank reset leaves the synchronizer two edges later
        repeat (3) @(negedge rclk);

        start_test();
        check_status(PWR_ON, 1'b1, 1'b0);
        check_value("rdata", rdata, 8'h00);
        end_test("after reset");

        start_test();
        for (int i = 0; i < `RF_DEPTH; i++) begin
            d     = $random(seed);
            sb[i] = d;
            write_word(i, d);
        end
        for (int i = 0; i < `RF_DEPTH; i++) begin
            a = $random(seed);
            read_check(a, sb[a]);
        end
        end_test("write and read back");

        start_test();
        @(negedge rclk);
        sleep_req = 1'b1;
        @(negedge rclk);
        check_status(PWR_ISOLATE, 1'b0, 1'b1);
        check_value("rdata", rdata, 8'h00);
        @(negedge rclk);
        check_status(PWR_OFF, 1'b0, 1'b1);
        // Reads while asleep return zero.
        // The writes go to addresses that are all rewritten after wake
        for (int i = 0; i < 4; i++) begin
            write_word($random(seed), $random(seed));
            read_check($random(seed), 8'h00);
        end
        end_test("sleep entry");

        start_test();
        sleep_req = 1'b0;
        wait_pwr_on(40);
        check_status(PWR_ON, 1'b1, 1'b0);
        a     = $random(seed);
        d     = $random(seed) | 1;
        sb[a] = d;
        write_word(a, d);
        read_check(a, d);
        end_test("wake");

        start_test();
        for (int i = 0; i < `RF_DEPTH; i++) begin
            d     = $random(seed);
            sb[i] = d;
            write_word(i, d);
        end
        for (int i = 0; i < `RF_DEPTH; i++) begin
            read_check(i, sb[i]);
        end
        end_test("rewrite after wake");

        start_test();
        // A nonzero word left on rdata shows the bypass reset clearing it
        a     = $random(seed);
        d     = $random(seed) | 1;
        sb[a] = d;
        write_word(a, d);
        read_check(a, d);
        @(negedge rclk);
        fscan_rstbypen = 1'b1;
        @(negedge rclk);
        fscan_byprst_b = 1'b0;
        @(negedge rclk);
        check_value("rdata", rdata, 8'h00);
        fscan_byprst_b = 1'b1;
        @(negedge rclk);
        check_status(PWR_ON, 1'b1, 1'b0);
        for (int i = 0; i < 8; i++) begin
            a     = $random(seed);
            d     = $random(seed);
            sb[a] = d;
            write_word(a, d);
            read_check(a, d);
        end
        fscan_rstbypen = 1'b0;
        end_test("scan reset bypass");

        $display("Tests: %0d, checks: %0d, errors: %0d", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rf_pg_top.f ====
+incdir+design
design/rf_mem_pkg.sv
design/rf_pwr_pkg.sv
design/rf_reset_sync.sv
design/rf_pwr_switch_chain.sv
design/rf_array.sv
design/rf_pg_bank.sv
design/rf_pwr_ctrl.sv
design/rf_pg_top.sv
tests/rf_pg_tb.sv
